// ==== common/dyn_trig_consts.svh ====
`ifndef DYN_TRIG_CONSTS_SVH
`define DYN_TRIG_CONSTS_SVH

// sample path delays
`define COR_PRE_DLY 15             // corrected sample pre-delay in clocks
`define PILEUP_DLY 3               // tap into the pileup line
`define TAP_MAX 16                 // programmable delay depth

// spy packet format
`define SPY_PREAMBLE 16'hA5A5      // first word of every packet
`define NWORDS_ENERGY 6'd1         // energy only
`define NWORDS_RAW 6'd33           // 32 raw samples plus energy
`define NWORDS_COR 6'd33           // 32 corrected samples plus energy
`define NWORDS_SHORT 6'd17         // 16 corrected samples plus energy

// spy fifo sizing
`define SPY_FIFO_DEPTH 64
`define SPY_NEARLY_FULL_MARGIN 8   // free slots below which full flag rises

// coincidence trigger byte
`define TRIG_IDLE_CODE 8'hFF       // no event this clock
`define TRIG_CLAMP_CODE 8'hF8      // time too late in the tick

`endif

// ==== common/dyn_trig_pkg.sv ====
package dyn_trig_pkg;

   // sample widths
   typedef logic [7:0]  adc_raw_t;   // raw dynode adc sample
   typedef logic [11:0] adc_cor_t;   // baseline corrected, also any delayed sample

   // event timing and energy
   typedef logic [23:0] evt_time_t;  // whole ticks in upper bits, fraction in [11:0]
   typedef logic [11:0] energy_t;    // corrected integrated energy

   // spy readout
   typedef logic [15:0] spy_word_t;  // one fifo word

   // packet framer sequence
   typedef enum logic [2:0] {
      fs_idle     = 3'd0,  // waiting for load request
      fs_preamble = 3'd1,  // emit preamble
      fs_nwords   = 3'd2,  // emit word count
      fs_mask     = 3'd3,  // emit channel mask
      fs_data     = 3'd4   // samples then energy
   } framer_state_t;

endpackage

// ==== logic/sample_delay.sv ====
`include "dyn_trig_consts.svh"

module sample_delay (
   input  logic                   clk,
   input  dyn_trig_pkg::adc_raw_t adc_raw,
   input  dyn_trig_pkg::adc_cor_t adc_cor,
   input  logic [1:0]             data_mode,
   input  logic [3:0]             data_tap,
   output dyn_trig_pkg::adc_cor_t delayed_sample
);
   import dyn_trig_pkg::*;

   localparam int PILE_LEN = 8;        // stages in the pileup line

   adc_cor_t cor_line  [`COR_PRE_DLY];  // aligns corrected data with raw path
   adc_cor_t pile_line [PILE_LEN];      // stage 0 is the source select reg
   adc_cor_t tap_line  [`TAP_MAX];      // programmable depth line

   // corrected sample pre-delay
   always_ff @(posedge clk) begin
      cor_line[0] <= adc_cor;
      for (int i = 1; i < `COR_PRE_DLY; i++) begin
         cor_line[i] <= cor_line[i-1];  // plain shift
      end
   end

   // source select then pileup line
   always_ff @(posedge clk) begin
      if (data_mode == 2'b01) begin
         pile_line[0] <= {4'h0, adc_raw};           // raw mode, zero extend
      end else begin
         pile_line[0] <= cor_line[`COR_PRE_DLY-1];  // baseline corrected
      end
      for (int i = 1; i < PILE_LEN; i++) begin
         pile_line[i] <= pile_line[i-1];
      end
   end

   // programmable delay and output reg
   always_ff @(posedge clk) begin
      tap_line[0] <= pile_line[`PILEUP_DLY];  // pick off at pileup point
      for (int i = 1; i < `TAP_MAX; i++) begin
         tap_line[i] <= tap_line[i-1];
      end
      delayed_sample <= tap_line[data_tap];   // tap 0 gives 6 clocks total
   end

endmodule

// ==== logic/trigger_time_encoder.sv ====
`include "dyn_trig_consts.svh"

module trigger_time_encoder (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    event_strobe,
   input  dyn_trig_pkg::evt_time_t event_time,
   output logic [7:0]              mcu_trigger_out,
   output logic [11:0]             event_whole,
   output logic [11:0]             event_frac
);

   // coincidence byte, one per clock
   always_ff @(posedge clk) begin
      if (rst) begin
         mcu_trigger_out <= `TRIG_IDLE_CODE;
      end else if (!event_strobe) begin
         mcu_trigger_out <= `TRIG_IDLE_CODE;   // nothing to report
      end else if (event_time[11:6] == 6'h3F) begin
         mcu_trigger_out <= `TRIG_CLAMP_CODE;  // keep clear of idle code
      end else begin
         mcu_trigger_out <= event_time[11:4];  // coarse time within tick
      end
   end

   // whole ticks and fraction for the event record
   always_ff @(posedge clk) begin
      event_whole <= {4'h0, event_time[19:12]};  // zero extended tick count
      event_frac  <= event_time[11:0];
   end

endmodule

// ==== readout/packet_framer.sv ====
`include "dyn_trig_consts.svh"

module packet_framer (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    energy_strobe,
   input  dyn_trig_pkg::energy_t   energy,
   input  logic                    trigger,
   input  logic [1:0]              data_mode,
   input  logic [1:0]              channel_select,
   input  dyn_trig_pkg::adc_cor_t  delayed_sample,
   output logic                    spy_wen,
   output dyn_trig_pkg::spy_word_t spy_wdata
);
   import dyn_trig_pkg::*;

   framer_state_t state;      // packet sequencer
   logic          load_req;   // registered request
   energy_t       energy_q;   // energy of the latest strobe
   logic [5:0]    nwords;     // words after the mask
   logic [3:0]    chan_mask;  // one-hot channel
   logic [5:0]    word_cnt;   // words still to send in fs_data

   // load request, energy wins over external trigger
   always_ff @(posedge clk) begin
      if (rst) begin
         load_req <= 1'b0;
      end else if (energy_strobe) begin
         load_req <= 1'b1;
      end else begin
         load_req <= trigger;
      end
   end

   always_ff @(posedge clk) begin
      if (energy_strobe) begin
         energy_q <= energy;  // held until next strobe
      end
   end

   // word count by mode
   always_comb begin
      case (data_mode)
         2'b00:   nwords = `NWORDS_ENERGY;
         2'b01:   nwords = `NWORDS_RAW;
         2'b10:   nwords = `NWORDS_COR;
         default: nwords = `NWORDS_SHORT;
      endcase
   end

   assign chan_mask = 4'b0001 << channel_select;  // bits 3..0 only

   // sequencer and write strobe
   always_ff @(posedge clk) begin
      if (rst) begin
         state    <= fs_idle;
         spy_wen  <= 1'b0;
         word_cnt <= '0;
      end else begin
         case (state)
            fs_idle: begin
               spy_wen  <= 1'b0;
               word_cnt <= nwords;  // reload every idle clock
               if (load_req) begin
                  state <= fs_preamble;
               end
            end
            fs_preamble: begin
               spy_wen <= 1'b1;
               state   <= fs_nwords;
            end
            fs_nwords: begin
               spy_wen <= 1'b1;
               state   <= fs_mask;
            end
            fs_mask: begin
               spy_wen <= 1'b1;
               state   <= fs_data;
            end
            fs_data: begin
               if (word_cnt == 6'd0) begin
                  spy_wen <= 1'b0;   // energy already out
                  state   <= fs_idle;
               end else begin
                  spy_wen  <= 1'b1;  // samples, then energy at count 1
                  word_cnt <= word_cnt - 6'd1;
               end
            end
            default: begin
               spy_wen <= 1'b0;
               state   <= fs_idle;
            end
         endcase
      end
   end

   // word mux, lines up with spy_wen
   always_ff @(posedge clk) begin
      case (state)
         fs_preamble: spy_wdata <= `SPY_PREAMBLE;
         fs_nwords:   spy_wdata <= {10'h000, nwords};
         fs_mask:     spy_wdata <= {12'h000, chan_mask};
         fs_data: begin
            if (word_cnt == 6'd1) begin
               spy_wdata <= {4'h0, energy_q};        // last word of packet
            end else begin
               spy_wdata <= {4'h0, delayed_sample};  // one sample per clock
            end
         end
         default:     spy_wdata <= spy_wdata;
      endcase
   end

endmodule

// ==== readout/spy_fifo.sv ====
`include "dyn_trig_consts.svh"

module spy_fifo #(
   parameter int DEPTH = `SPY_FIFO_DEPTH  // power of two
) (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    wen,
   input  dyn_trig_pkg::spy_word_t wdata,
   input  logic                    ren,
   output dyn_trig_pkg::spy_word_t q,
   output logic                    ne,
   output logic                    nearly_full
);
   import dyn_trig_pkg::*;

   localparam int AW = $clog2(DEPTH);
   localparam int CW = AW + 1;
   localparam logic [CW-1:0] FULL_CNT = CW'(DEPTH);
   localparam logic [CW-1:0] HIGH_CNT = CW'(DEPTH - `SPY_NEARLY_FULL_MARGIN);

   spy_word_t       mem [DEPTH];
   logic [AW-1:0]   wr_ptr;
   logic [AW-1:0]   rd_ptr;
   logic [CW-1:0]   count;   // occupancy
   logic            do_wr;
   logic            do_rd;

   assign do_wr = wen && (count != FULL_CNT);  // drop when full
   assign do_rd = ren && (count != '0);        // ignore when empty

   always_ff @(posedge clk) begin
      if (do_wr) begin
         mem[wr_ptr] <= wdata;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
         end
         if (do_rd) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_wr, do_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;  // both or neither
         endcase
      end
   end

   assign q           = mem[rd_ptr];       // show-ahead head word
   assign ne          = (count != '0);
   assign nearly_full = (count > HIGH_CNT);  // fewer than margin free

endmodule

// ==== logic/trigger_readout_top.sv ====
module trigger_readout_top (
   input  logic                    clk,
   input  logic                    rst,
   input  dyn_trig_pkg::adc_raw_t  adc_raw,
   input  dyn_trig_pkg::adc_cor_t  adc_cor,
   input  logic                    event_strobe,
   input  dyn_trig_pkg::evt_time_t event_time,
   input  logic                    energy_strobe,
   input  dyn_trig_pkg::energy_t   energy,
   input  logic                    trigger,
   input  logic [1:0]              data_mode,
   input  logic [3:0]              data_tap,
   input  logic [1:0]              channel_select,
   input  logic                    spy_ren,
   output logic [7:0]              mcu_trigger_out,
   output logic                    event_trigger_out,
   output dyn_trig_pkg::evt_time_t event_time_out,
   output logic [11:0]             event_whole,
   output logic [11:0]             event_frac,
   output dyn_trig_pkg::spy_word_t spy_q,
   output logic                    spy_ne,
   output logic                    spy_full
);
   import dyn_trig_pkg::*;

   adc_cor_t  delayed_sample;  // aligned sample into the framer
   logic      spy_wen;
   spy_word_t spy_wdata;

   // coincidence trigger straight through
   assign event_trigger_out = event_strobe;
   assign event_time_out    = event_time;

   sample_delay i_sample_delay (
      .clk            (clk),
      .adc_raw        (adc_raw),
      .adc_cor        (adc_cor),
      .data_mode      (data_mode),
      .data_tap       (data_tap),
      .delayed_sample (delayed_sample)
   );

   trigger_time_encoder i_trigger_time_encoder (
      .clk             (clk),
      .rst             (rst),
      .event_strobe    (event_strobe),
      .event_time      (event_time),
      .mcu_trigger_out (mcu_trigger_out),
      .event_whole     (event_whole),
      .event_frac      (event_frac)
   );

   packet_framer i_packet_framer (
      .clk            (clk),
      .rst            (rst),
      .energy_strobe  (energy_strobe),
      .energy         (energy),
      .trigger        (trigger),
      .data_mode      (data_mode),
      .channel_select (channel_select),
      .delayed_sample (delayed_sample),
      .spy_wen        (spy_wen),
      .spy_wdata      (spy_wdata)
   );

   spy_fifo i_spy_fifo (
      .clk         (clk),
      .rst         (rst),
      .wen         (spy_wen),
      .wdata       (spy_wdata),
      .ren         (spy_ren),
      .q           (spy_q),
      .ne          (spy_ne),
      .nearly_full (spy_full)
   );

endmodule

// ==== test/trigger_readout_props.sv ====
`include "dyn_trig_consts.svh"

module trigger_readout_props (
   input  logic                        clk,
   input  logic                        rst,
   input  dyn_trig_pkg::framer_state_t fr_state,
   input  logic                        spy_wen,
   input  dyn_trig_pkg::spy_word_t     spy_wdata,
   input  logic                        event_strobe,
   input  logic [7:0]                  mcu_trigger_out
);
   import dyn_trig_pkg::*;

   // framer writes only while a packet is running
   idle_no_write: assert property (
      @(posedge clk) disable iff (rst)
      (fr_state == fs_idle) |-> !spy_wen
   ) else $error("spy write strobe high while framer idle");

   // every packet opens with the preamble
   first_word_preamble: assert property (
      @(posedge clk) disable iff (rst)
      $rose(spy_wen) |-> (spy_wdata == `SPY_PREAMBLE)
   ) else $error("first packet word is not the preamble");

   // no event gives the idle byte one clock later
   idle_trigger_code: assert property (
      @(posedge clk) disable iff (rst)
      !event_strobe |=> (mcu_trigger_out == `TRIG_IDLE_CODE)
   ) else $error("trigger byte not idle after a clock without event");

endmodule

// ==== test/tb_trigger_readout.sv ====
`include "dyn_trig_consts.svh"

module tb_trigger_readout;
   import dyn_trig_pkg::*;

   localparam int MAX_CYCLES = 3000;  // about five long packets plus settling

   logic       clk = 1'b0;
   logic       rst = 1'b1;
   adc_raw_t   adc_raw = '0;
   adc_cor_t   adc_cor = '0;
   logic       event_strobe = 1'b0;
   evt_time_t  event_time = '0;
   logic       energy_strobe = 1'b0;
   energy_t    energy = '0;
   logic       trigger = 1'b0;
   logic [1:0] data_mode = 2'b00;
   logic [3:0] data_tap = 4'd0;
   logic [1:0] channel_select = 2'b00;
   logic       spy_ren = 1'b0;
   logic [7:0] mcu_trigger_out;
   logic       event_trigger_out;
   evt_time_t  event_time_out;
   logic [11:0] event_whole;
   logic [11:0] event_frac;
   spy_word_t  spy_q;
   logic       spy_ne;
   logic       spy_full;

   logic [11:0] sample_cnt = '0;    // ramp source for the adc inputs
   logic        hold_cor = 1'b0;    // freeze corrected sample
   adc_cor_t    hold_val = '0;
   int          cycle_cnt = 0;
   integer      seed = 32'hc075;

   trigger_readout_top i_trigger_readout_top (.*);

   bind trigger_readout_top trigger_readout_props i_props (
      .clk             (clk),
      .rst             (rst),
      .fr_state        (i_packet_framer.state),
      .spy_wen         (spy_wen),
      .spy_wdata       (spy_wdata),
      .event_strobe    (event_strobe),
      .mcu_trigger_out (mcu_trigger_out)
   );

   always #5 clk = ~clk;  // period 10

   // adc ramps by one per clock
   always @(posedge clk) begin
      sample_cnt <= sample_cnt + 12'd1;
      adc_raw    <= sample_cnt[7:0];
      adc_cor    <= hold_cor ? hold_val : sample_cnt;
   end

   // watchdog
   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= MAX_CYCLES) begin
         $display("timeout after %0d cycles waiting for the DUT", cycle_cnt);
         $display("Simulation finished: FAIL");
         $fatal(1);
      end
   end

   task automatic stop_on_error(input string msg);
      $display("%s", msg);
      $display("Simulation finished: FAIL");
      $fatal(1);
   endtask

   task automatic check_value(input string test, input logic [23:0] exp,
                              input logic [23:0] act);
      assert (exp === act) else begin
         stop_on_error($sformatf("[ERROR] %s expected %h actual %h", test, exp, act));
      end
   endtask

   // static controls then let the delay lines fill
   task automatic set_controls(input logic [1:0] mode, input logic [3:0] tap,
                               input logic [1:0] chan);
      @(posedge clk);
      data_mode      <= mode;
      data_tap       <= tap;
      channel_select <= chan;
      repeat (40) @(posedge clk);
   endtask

   task automatic pulse_request(input logic trig, input logic estb, input energy_t e);
      @(posedge clk);
      trigger       <= trig;
      energy_strobe <= estb;
      energy        <= e;
      @(posedge clk);
      trigger       <= 1'b0;
      energy_strobe <= 1'b0;
   endtask

   // waits for a word at the head, then pops it
   task automatic pop_word(output spy_word_t w);
      @(negedge clk);
      while (!spy_ne) begin
         @(negedge clk);
      end
      w = spy_q;
      @(posedge clk);
      spy_ren <= 1'b1;
      @(posedge clk);
      spy_ren <= 1'b0;
   endtask

   task automatic drain_and_check(input string test, input spy_word_t exp[$]);
      spy_word_t w;
      foreach (exp[i]) begin
         pop_word(w);
         check_value(test, 24'(exp[i]), 24'(w));
      end
      repeat (10) @(posedge clk);
      @(negedge clk);
      assert (!spy_ne) else begin
         stop_on_error($sformatf("%s left extra words in the spy FIFO", test));
      end
   endtask

   task automatic test_reset_state();
      @(negedge clk);
      check_value("reset_state", 24'(1'b0), 24'(spy_ne));
      check_value("reset_state", 24'(1'b0), 24'(spy_full));
      check_value("reset_state", 24'(`TRIG_IDLE_CODE), 24'(mcu_trigger_out));
   endtask

   task automatic test_trigger_time();
      evt_time_t  t;
      logic [7:0] exp_code;
      for (int i = 0; i < 12; i++) begin
         t = evt_time_t'($random(seed));
         if (i % 3 == 0) begin
            t[11:6] = 6'h3F;  // force the late clamp
         end
         exp_code = (t[11:6] == 6'h3F) ? `TRIG_CLAMP_CODE : t[11:4];
         @(posedge clk);
         event_strobe <= 1'b1;
         event_time   <= t;
         @(negedge clk);
         check_value("trigger_time", 24'(1'b1), 24'(event_trigger_out));  // same clock
         check_value("trigger_time", 24'(t), 24'(event_time_out));
         @(posedge clk);
         event_strobe <= 1'b0;
         @(negedge clk);
         check_value("trigger_time", 24'(exp_code), 24'(mcu_trigger_out));
         check_value("trigger_time", 24'({4'h0, t[19:12]}), 24'(event_whole));
         check_value("trigger_time", 24'(t[11:0]), 24'(event_frac));
         check_value("trigger_time", 24'(1'b0), 24'(event_trigger_out));
         @(posedge clk);
         @(negedge clk);
         check_value("trigger_time", 24'(`TRIG_IDLE_CODE), 24'(mcu_trigger_out));
      end
   endtask

   task automatic test_energy_packet();
      spy_word_t exp[$];
      set_controls(2'b00, 4'd0, 2'd2);
      pulse_request(1'b0, 1'b1, 12'h123);
      exp = '{16'hA5A5, 16'h0001, 16'h0004, 16'h0123};
      drain_and_check("energy_packet", exp);
   endtask

   task automatic test_raw_packet();
      spy_word_t w;
      spy_word_t prev;
      set_controls(2'b01, 4'd3, 2'd1);
      pulse_request(1'b1, 1'b0, 12'h000);
      pop_word(w);
      check_value("raw_packet", 24'h00A5A5, 24'(w));
      pop_word(w);
      check_value("raw_packet", 24'h000021, 24'(w));
      pop_word(w);
      check_value("raw_packet", 24'h000002, 24'(w));
      pop_word(prev);
      check_value("raw_packet", 24'h0, 24'(prev[15:8]));  // upper byte zero
      for (int i = 1; i < 32; i++) begin
         pop_word(w);
         check_value("raw_packet", 24'({8'h00, prev[7:0] + 8'd1}), 24'(w));
         prev = w;
      end
      pop_word(w);
      check_value("raw_packet", 24'h000123, 24'(w));  // energy from earlier strobe
      repeat (10) @(posedge clk);
      @(negedge clk);
      assert (!spy_ne) else begin
         stop_on_error("raw_packet left extra words in the spy FIFO");
      end
   endtask

   task automatic test_short_cor_packet();
      spy_word_t exp[$];
      @(posedge clk);
      hold_val <= 12'h7AB;
      hold_cor <= 1'b1;
      set_controls(2'b11, 4'd5, 2'd0);  // 40 clocks exceeds 6 + 15 + 5
      pulse_request(1'b1, 1'b0, 12'h000);
      exp = '{16'hA5A5, 16'h0011, 16'h0001};
      for (int i = 0; i < 16; i++) begin
         exp.push_back(16'h07AB);
      end
      exp.push_back(16'h0123);
      drain_and_check("short_cor_packet", exp);
      hold_cor <= 1'b0;
   endtask

   task automatic test_ignore_and_priority();
      spy_word_t exp[$];
      set_controls(2'b11, 4'd0, 2'd0);
      pulse_request(1'b1, 1'b0, 12'h000);
      repeat (8) @(posedge clk);
      pulse_request(1'b1, 1'b0, 12'h000);  // lands mid packet
      exp = '{16'hA5A5, 16'h0011, 16'h0001};
      for (int i = 0; i < 16; i++) begin
         exp.push_back(16'hxxxx);
      end
      exp.push_back(16'h0123);
      begin
         spy_word_t w;
         foreach (exp[i]) begin
            pop_word(w);
            if (i < 3 || i == 19) begin
               check_value("ignore_request", 24'(exp[i]), 24'(w));
            end
         end
         repeat (10) @(posedge clk);
         @(negedge clk);
         assert (!spy_ne) else begin
            stop_on_error("ignore_request produced a second packet");
         end
      end
      set_controls(2'b00, 4'd0, 2'd3);
      pulse_request(1'b1, 1'b1, 12'h456);  // both at once
      exp = '{16'hA5A5, 16'h0001, 16'h0008, 16'h0456};
      drain_and_check("request_priority", exp);
   endtask

   initial begin
      repeat (5) @(posedge clk);
      rst <= 1'b0;
      test_reset_state();
      test_trigger_time();
      test_energy_packet();
      test_raw_packet();
      test_short_cor_packet();
      test_ignore_and_priority();
      $display("Simulation finished: PASS");
      $finish;
   end

endmodule

// ==== filelist.f ====
+incdir+common
common/dyn_trig_pkg.sv
logic/sample_delay.sv
logic/trigger_time_encoder.sv
readout/packet_framer.sv
readout/spy_fifo.sv
logic/trigger_readout_top.sv
test/trigger_readout_props.sv
test/tb_trigger_readout.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 \
   --top-module tb_trigger_readout \
   -f filelist.f \
   -o sim_trigger_readout

output=$(./obj_dir/sim_trigger_readout 2>&1) || true
echo "$output"

if echo "$output" | grep -q "Simulation finished: PASS"; then
   exit 0
else
   exit 1
fi
